// ==== source/br_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch unit package: widths, opcodes, vector types
// and the resolve control state enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package br_pkg;

	// Datapath widths
	localparam int ADDR_W     = 64;
	localparam int INST_W     = 32;
	localparam int OPCODE_W   = 6;  // Alpha major opcode, inst[31:26]
	localparam int DISP_W     = 21; // Branch displacement field

	// Reorder buffer
	localparam int ROB_IDX_W  = 5;

	// Predictor table, indexed by PC[7:2]
	localparam int BHT_IDX_W   = 6;
	localparam int BHT_ENTRIES = 1 << BHT_IDX_W;
	localparam int CTR_W       = 2;

	// Resolve control
	localparam int SQUASH_CYCLES = 2; // Wrong-path window after recovery
	localparam int SQ_CNT_W      = 2;
	localparam int MISP_CNT_W    = 16;

	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [INST_W-1:0]    inst_t;
	typedef logic [OPCODE_W-1:0]  opcode_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [BHT_IDX_W-1:0] bht_idx_t;
	typedef logic [CTR_W-1:0]     bht_ctr_t;

	// Counter reset value, weakly not taken
	localparam bht_ctr_t CTR_INIT = 2'b01;

	// Opcodes handled here
	localparam opcode_t OP_JMP      = 6'h1A; // JMP/JSR/RET group
	localparam opcode_t OP_BR       = 6'h30;
	localparam opcode_t OP_BSR      = 6'h34;
	localparam opcode_t OP_CBR_BASE = 6'h38; // 0x38..0x3F conditional

	// Resolve control FSM
	typedef enum logic [0:0]
	{
		RS_IDLE,
		RS_SQUASH
	} ctrl_state_t;

endpackage

// ==== source/br_result_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Resolved branch bundle, execute unit to resolve control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface br_result_if import br_pkg::*; ();

	logic     done;        // One-cycle strobe, fields valid with it
	logic     taken;       // Actual outcome
	addr_t    target;      // Computed target
	addr_t    npc;         // Fall-through address
	rob_idx_t rob_idx;
	logic     is_cond;     // Conditional branch, trains predictor
	logic     pred_taken;  // Front end guess
	addr_t    pred_target;

	// Producer side
	modport exec (output done, taken, target, npc, rob_idx, is_cond,
		pred_taken, pred_target);

	// Consumer side
	modport ctrl (input done, taken, target, npc, rob_idx, is_cond,
		pred_taken, pred_target);

endinterface

// ==== source/br_cond_eval.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Alpha conditional branch test on a 64-bit register operand
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module br_cond_eval import br_pkg::*;
(
	input  addr_t      opa_i,  // Register A value
	input  logic [2:0] func_i, // Low opcode bits
	output logic       cond_o
);

	logic base; // Test result before inversion

	// BLBC/BEQ/BLT/BLE, with func_i[2] giving BLBS/BNE/BGE/BGT
	always_comb
	begin
		case (func_i[1:0])
			2'b00: base = ~opa_i[0];                        // Low bit clear
			2'b01: base = (opa_i == '0);                    // Equal zero
			2'b10: base = opa_i[ADDR_W-1];                  // Negative
			2'b11: base = opa_i[ADDR_W-1] || (opa_i == '0); // Less or equal zero
			default: base = 1'b0;
		endcase

		// Upper half of the opcode range inverts
		if (func_i[2])
		begin
			cond_o = ~base;
		end
		else
		begin
			cond_o = base;
		end
	end

endmodule

// ==== source/br_exec_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch execute stage with decode, target, outcome and result register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module br_exec_unit import br_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          issue_valid_i, // Single-cycle issue strobe
	input  addr_t         npc_i,
	input  addr_t         opa_i,
	input  inst_t         inst_i,
	input  rob_idx_t      rob_idx_i,
	input  logic          pred_taken_i,
	input  addr_t         pred_target_i,
	br_result_if.exec     res
);

	opcode_t opcode;
	logic    is_jmp;   // Register-indirect jump group
	logic    is_uncond; // BR/BSR
	logic    is_cond;
	logic    op_ok;
	logic    cond_res;
	logic    taken;
	addr_t   disp;
	addr_t   target;

	assign opcode    = inst_i[INST_W-1 -: OPCODE_W];
	assign is_jmp    = (opcode == OP_JMP);
	assign is_uncond = (opcode == OP_BR) || (opcode == OP_BSR);
	assign is_cond   = (opcode >= OP_CBR_BASE);
	assign op_ok     = is_jmp || is_uncond || is_cond;

	// Sign-extended word displacement
	assign disp = {{(ADDR_W-DISP_W-2){inst_i[DISP_W-1]}}, inst_i[DISP_W-1:0], 2'b00};

	// Jump target is the operand aligned to a word
	always_comb
	begin
		if (is_jmp)
		begin
			target = {opa_i[ADDR_W-1:2], 2'b00};
		end
		else
		begin
			target = npc_i + disp; // PC-relative
		end
	end

	br_cond_eval u_cond_eval
	(
		.opa_i  (opa_i),
		.func_i (inst_i[28:26]), // Condition code in opcode low bits
		.cond_o (cond_res)
	);

	assign taken = is_cond ? cond_res : 1'b1; // Others always taken

	// Result strobe one cycle after issue
	always_ff @(posedge clk)
	begin
		if (rst)
			res.done <= 1'b0;
		else
			res.done <= issue_valid_i;
	end

	// Result payload loaded on issue only
	always_ff @(posedge clk)
	begin
		if (issue_valid_i)
		begin
			res.taken       <= taken;
			res.target      <= target;
			res.npc         <= npc_i;
			res.rob_idx     <= rob_idx_i;
			res.is_cond     <= is_cond;
			res.pred_taken  <= pred_taken_i;
			res.pred_target <= pred_target_i;
		end
	end

	// Only supported opcodes issue
	a_issue_op: assert property (@(posedge clk) disable iff (rst)
		issue_valid_i |-> op_ok);

endmodule

// ==== source/br_predictor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-bit saturating counter table with lookup and update ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module br_predictor import br_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  lookup_valid_i,
	input  addr_t lookup_pc_i,
	output logic  pred_valid_o,
	output logic  pred_taken_o,
	input  logic  upd_valid_i,   // One-cycle training strobe
	input  addr_t upd_pc_i,
	input  logic  upd_taken_i
);

	bht_ctr_t bht [BHT_ENTRIES];
	bht_idx_t lk_idx;
	bht_idx_t up_idx;
	bht_ctr_t up_ctr;
	bht_ctr_t up_nxt;   // Counter after this cycle's update
	logic     bypass;

	// Word-aligned PC, bits 7:2
	assign lk_idx = lookup_pc_i[BHT_IDX_W+1:2];
	assign up_idx = upd_pc_i[BHT_IDX_W+1:2];
	assign up_ctr = bht[up_idx];

	// One step toward the outcome, saturating
	always_comb
	begin
		if (upd_taken_i)
			up_nxt = (up_ctr == '1) ? up_ctr : up_ctr + 1'b1;
		else
			up_nxt = (up_ctr == '0) ? up_ctr : up_ctr - 1'b1;
	end

	// Table write, all entries weakly not taken out of reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < BHT_ENTRIES; i++)
				bht[i] <= CTR_INIT;
		end
		else if (upd_valid_i)
		begin
			bht[up_idx] <= up_nxt;
		end
	end

	// Lookup hitting the entry written at this same edge
	assign bypass = upd_valid_i && (up_idx == lk_idx);

	always_ff @(posedge clk)
	begin
		if (rst)
			pred_valid_o <= 1'b0;
		else
			pred_valid_o <= lookup_valid_i;
	end

	// Prediction is the counter MSB
	always_ff @(posedge clk)
	begin
		if (bypass)
			pred_taken_o <= up_nxt[CTR_W-1];
		else
			pred_taken_o <= bht[lk_idx][CTR_W-1];
	end

endmodule

// ==== source/br_resolve_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Resolve control FSM with mispredict check, completion, recovery,
// squash, predictor training and mispredict count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module br_resolve_ctrl import br_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	br_result_if.ctrl             res,
	output logic                  upd_valid_o,
	output addr_t                 upd_pc_o,
	output logic                  upd_taken_o,
	output logic                  complete_valid_o,
	output rob_idx_t              complete_rob_idx_o,
	output logic                  complete_taken_o,
	output logic                  recovery_valid_o,
	output addr_t                 recovery_target_o,
	output rob_idx_t              recovery_rob_idx_o,
	output logic [MISP_CNT_W-1:0] mispredict_count_o
);

	ctrl_state_t         state;
	logic [SQ_CNT_W-1:0] sq_cnt;  // Cycles left in squash window
	logic                accept;  // Result not on the wrong path
	logic                mispred;

	assign accept = res.done && (state == RS_IDLE);

	// Wrong direction, or taken to the wrong place
	assign mispred = (res.taken != res.pred_taken) ||
		(res.taken && (res.target != res.pred_target));

	// FSM and counters
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state              <= RS_IDLE;
			sq_cnt             <= '0;
			mispredict_count_o <= '0;
		end
		else
		begin
			case (state)
				RS_IDLE:
				begin
					if (accept && mispred)
					begin
						state              <= RS_SQUASH;
						sq_cnt             <= SQ_CNT_W'(SQUASH_CYCLES - 1);
						mispredict_count_o <= mispredict_count_o + 1'b1;
					end
				end
				RS_SQUASH:
				begin
					if (sq_cnt == '0)
						state <= RS_IDLE;   // Window over
					else
						sq_cnt <= sq_cnt - 1'b1;
				end
				default: state <= RS_IDLE;
			endcase
		end
	end

	// Output strobes
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			complete_valid_o <= 1'b0;
			recovery_valid_o <= 1'b0;
			upd_valid_o      <= 1'b0;
		end
		else
		begin
			complete_valid_o <= accept;
			recovery_valid_o <= accept && mispred;
			upd_valid_o      <= accept && res.is_cond; // Conditional only
		end
	end

	// Output payload qualified by the strobes above
	always_ff @(posedge clk)
	begin
		complete_rob_idx_o <= res.rob_idx;
		complete_taken_o   <= res.taken;
		recovery_rob_idx_o <= res.rob_idx;
		recovery_target_o  <= res.taken ? res.target : res.npc; // Correct fetch PC
		upd_pc_o           <= res.npc - ADDR_W'(4);             // Branch's own PC
		upd_taken_o        <= res.taken;
	end

	// Recovery comes with completion and then the window stays silent
	a_recov_window: assert property (@(posedge clk) disable iff (rst)
		recovery_valid_o |-> complete_valid_o ##1 (!complete_valid_o)[*SQUASH_CYCLES]);

	// Squash state lasts exactly the window length, then back to idle
	a_squash_len: assert property (@(posedge clk) disable iff (rst)
		$rose(state == RS_SQUASH) |->
			(state == RS_SQUASH)[*SQUASH_CYCLES] ##1 (state == RS_IDLE));

endmodule

// ==== source/br_unit_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch resolution unit top: execute, predictor, resolve control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module br_unit_top import br_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	// Issue from the scheduler
	input  logic                  issue_valid_i,
	input  addr_t                 issue_npc_i,
	input  addr_t                 issue_opa_i,
	input  inst_t                 issue_inst_i,
	input  rob_idx_t              issue_rob_idx_i,
	input  logic                  issue_pred_taken_i,
	input  addr_t                 issue_pred_target_i,
	// Front end lookup
	input  logic                  fetch_valid_i,
	input  addr_t                 fetch_pc_i,
	output logic                  pred_valid_o,
	output logic                  pred_taken_o,
	// To the ROB and fetch
	output logic                  complete_valid_o,
	output rob_idx_t              complete_rob_idx_o,
	output logic                  complete_taken_o,
	output logic                  recovery_valid_o,
	output addr_t                 recovery_target_o,
	output rob_idx_t              recovery_rob_idx_o,
	output logic [MISP_CNT_W-1:0] mispredict_count_o
);

	br_result_if res_if ();

	// Predictor training path
	logic  upd_valid;
	addr_t upd_pc;
	logic  upd_taken;

	br_exec_unit u_exec
	(
		.clk           (clk),
		.rst           (rst),
		.issue_valid_i (issue_valid_i),
		.npc_i         (issue_npc_i),
		.opa_i         (issue_opa_i),
		.inst_i        (issue_inst_i),
		.rob_idx_i     (issue_rob_idx_i),
		.pred_taken_i  (issue_pred_taken_i),
		.pred_target_i (issue_pred_target_i),
		.res           (res_if.exec)
	);

	br_predictor u_pred
	(
		.clk            (clk),
		.rst            (rst),
		.lookup_valid_i (fetch_valid_i),
		.lookup_pc_i    (fetch_pc_i),
		.pred_valid_o   (pred_valid_o),
		.pred_taken_o   (pred_taken_o),
		.upd_valid_i    (upd_valid),
		.upd_pc_i       (upd_pc),
		.upd_taken_i    (upd_taken)
	);

	br_resolve_ctrl u_ctrl
	(
		.clk                (clk),
		.rst                (rst),
		.res                (res_if.ctrl),
		.upd_valid_o        (upd_valid),
		.upd_pc_o           (upd_pc),
		.upd_taken_o        (upd_taken),
		.complete_valid_o   (complete_valid_o),
		.complete_rob_idx_o (complete_rob_idx_o),
		.complete_taken_o   (complete_taken_o),
		.recovery_valid_o   (recovery_valid_o),
		.recovery_target_o  (recovery_target_o),
		.recovery_rob_idx_o (recovery_rob_idx_o),
		.mispredict_count_o (mispredict_count_o)
	);

endmodule

// ==== tests/br_tb_clkgen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock, 20 ns period, and 2-cycle reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module br_tb_clkgen
(
	output logic clk_o,
	output logic rst_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o; // 20 ns period
	end

	// Released 1 ns after the second edge, like the other inputs
	initial
	begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_o);
		#1 rst_o = 1'b0;
	end

endmodule

// ==== tests/br_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch unit testbench with stimulus, reference model, checks and timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module br_tb import br_pkg::*; ();

	localparam int TIMEOUT_CYC = 2000; // Stimulus is about 250 cycles long

	// One issued branch as the model sees it
	typedef struct packed
	{
		logic        taken;
		addr_t       target;
		addr_t       npc;
		rob_idx_t    rob_idx;
		logic        is_cond;
		logic        pred_taken;
		addr_t       pred_target;
		logic [31:0] cyc;       // Issue cycle
	} br_rec_t;

	logic clk;
	logic rst;
	logic issue_valid, issue_pred_taken, fetch_valid;
	addr_t issue_npc, issue_opa, issue_pred_target, fetch_pc;
	inst_t issue_inst;
	rob_idx_t issue_rob_idx;
	logic pred_valid, pred_taken, complete_valid, complete_taken, recovery_valid;
	rob_idx_t complete_rob_idx, recovery_rob_idx;
	addr_t recovery_target;
	logic [MISP_CNT_W-1:0] mispredict_count;

	logic [31:0] cyc = '0;
	int val_errs = 0;
	int misc_errs = 0;
	logic look_fixed;  // Lookups held on one PC
	addr_t look_pc;

	// Model state and expected outputs
	br_rec_t br_q [$];
	bht_ctr_t m_bht [BHT_ENTRIES];
	int m_sq;
	int m_miss;
	logic m_upd_v, m_upd_t;
	bht_idx_t m_upd_idx;
	logic exp_pv, exp_pt, exp_cv, exp_ct, exp_rv;
	rob_idx_t exp_crob, exp_rrob;
	addr_t exp_rtgt;
	logic [MISP_CNT_W-1:0] exp_mc;

	br_tb_clkgen u_clkgen (.clk_o (clk), .rst_o (rst));

	br_unit_top dut
	(
		.clk (clk), .rst (rst),
		.issue_valid_i (issue_valid), .issue_npc_i (issue_npc), .issue_opa_i (issue_opa),
		.issue_inst_i (issue_inst), .issue_rob_idx_i (issue_rob_idx),
		.issue_pred_taken_i (issue_pred_taken), .issue_pred_target_i (issue_pred_target),
		.fetch_valid_i (fetch_valid), .fetch_pc_i (fetch_pc),
		.pred_valid_o (pred_valid), .pred_taken_o (pred_taken),
		.complete_valid_o (complete_valid), .complete_rob_idx_o (complete_rob_idx),
		.complete_taken_o (complete_taken), .recovery_valid_o (recovery_valid),
		.recovery_target_o (recovery_target), .recovery_rob_idx_o (recovery_rob_idx),
		.mispredict_count_o (mispredict_count)
	);

	// Alpha condition rule with signed compares on the operand
	function automatic logic ref_taken(input opcode_t op, input addr_t opa);
		logic t;
		if (op < OP_CBR_BASE)
			return 1'b1;        // BR, BSR, jumps
		case (op[1:0])
			2'd0: t = (opa[0] == 1'b0);
			2'd1: t = (opa == 64'd0);
			2'd2: t = ($signed(opa) < 64'sd0);
			default: t = ($signed(opa) <= 64'sd0);
		endcase
		return op[2] ? !t : t;
	endfunction

	function automatic addr_t ref_target(input inst_t inst, input addr_t npc, input addr_t opa);
		addr_t disp;
		if (inst[31:26] == OP_JMP)
			return opa & ~64'h3;
		disp = {{43{inst[20]}}, inst[20:0]};
		return npc + (disp << 2); // Word displacement
	endfunction

	function automatic bht_ctr_t ctr_step(input bht_ctr_t c, input logic t);
		if (t)
			return (c == 2'b11) ? c : c + 2'b01;
		return (c == 2'b00) ? c : c - 2'b01;
	endfunction

	function automatic addr_t rand_addr();
		return {$urandom(), $urandom()};
	endfunction

	function automatic addr_t rand_pc();
		return rand_addr() & ~64'h3;
	endfunction

	// Zero, positive, negative, odd and even operands
	function automatic addr_t pick_opa(input int k);
		case (k % 6)
			0: return 64'd0;
			1: return 64'd1;
			2: return 64'd2;
			3: return '1;                   // -1
			4: return {{63{1'b1}}, 1'b0};   // -2
			default: return rand_addr();
		endcase
	endfunction

	task automatic value_err(input string name, input addr_t got, input addr_t exp);
		val_errs++;
		$display("ERR %s: got %h exp %h at cycle %0d", name, got, exp, cyc);
	endtask

	// New lookup 1 ns after each edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
		fetch_valid = 1'b1;
		fetch_pc = look_fixed ? look_pc : rand_addr();
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	// One-cycle issue where wrong picks a bad direction or a bad target
	task automatic send_branch(input opcode_t op, input addr_t npc, input addr_t opa,
		input logic wrong);
		inst_t inst;
		logic  t;
		addr_t tgt;
		inst = {op, 5'($urandom()), 21'($urandom())};
		t = ref_taken(op, opa);
		tgt = ref_target(inst, npc, opa);
		issue_valid = 1'b1;
		issue_npc = npc;
		issue_opa = opa;
		issue_inst = inst;
		issue_rob_idx = rob_idx_t'($urandom());
		issue_pred_taken = t;
		issue_pred_target = t ? tgt : rand_addr(); // Target unused when not taken
		if (wrong && t && (($urandom() & 32'd1) != 0))
			issue_pred_target = tgt ^ 64'h4;
		else if (wrong)
			issue_pred_taken = !t;
		next_cycle();
		issue_valid = 1'b0;
	endtask

	// Reference model whose outputs line up with the DUT registers
	always @(posedge clk)
	begin : ref_model
		br_rec_t r;
		br_rec_t n;
		addr_t   upc;
		logic    due;
		if (rst)
		begin
			br_q.delete();
			for (int i = 0; i < BHT_ENTRIES; i++)
				m_bht[i] = 2'b01;
			m_sq = 0;
			m_miss = 0;
			m_upd_v = 1'b0;
			exp_pv <= 1'b0;
			exp_pt <= 1'b0;
			exp_cv <= 1'b0;
			exp_rv <= 1'b0;
			exp_mc <= '0;
		end
		else
		begin
			if (m_upd_v)   // Training lands one edge after completion
				m_bht[m_upd_idx] = ctr_step(m_bht[m_upd_idx], m_upd_t);
			m_upd_v = 1'b0;
			exp_pv <= fetch_valid;
			exp_pt <= m_bht[fetch_pc[7:2]][1];
			exp_cv <= 1'b0;
			exp_rv <= 1'b0;
			due = (br_q.size() > 0) && (br_q[0].cyc + 32'd1 == cyc);
			if (due)
				r = br_q.pop_front();
			if (m_sq > 0)
				m_sq = m_sq - 1;   // Wrong-path result dropped
			else if (due)
			begin
				exp_cv <= 1'b1;
				exp_ct <= r.taken;
				exp_crob <= r.rob_idx;
				if ((r.taken != r.pred_taken) || (r.taken && (r.target != r.pred_target)))
				begin
					exp_rv <= 1'b1;
					exp_rtgt <= r.taken ? r.target : r.npc;
					exp_rrob <= r.rob_idx;
					m_miss++;
					m_sq = SQUASH_CYCLES;
				end
				if (r.is_cond)
				begin
					upc = r.npc - 64'd4;
					m_upd_v = 1'b1;
					m_upd_idx = upc[7:2];
					m_upd_t = r.taken;
				end
			end
			exp_mc <= MISP_CNT_W'(m_miss);
			if (issue_valid)
			begin
				n.taken = ref_taken(issue_inst[31:26], issue_opa);
				n.target = ref_target(issue_inst, issue_npc, issue_opa);
				n.npc = issue_npc;
				n.rob_idx = issue_rob_idx;
				n.is_cond = (issue_inst[31:26] >= OP_CBR_BASE);
				n.pred_taken = issue_pred_taken;
				n.pred_target = issue_pred_target;
				n.cyc = cyc;
				br_q.push_back(n);
			end
		end
	end

	a_cv: assert property (@(posedge clk) disable iff (rst) complete_valid == exp_cv)
		else value_err("complete_valid_o", 64'($sampled(complete_valid)), 64'($sampled(exp_cv)));
	a_ct: assert property (@(posedge clk) disable iff (rst)
		complete_valid |-> complete_taken == exp_ct)
		else value_err("complete_taken_o", 64'($sampled(complete_taken)), 64'($sampled(exp_ct)));
	a_crob: assert property (@(posedge clk) disable iff (rst)
		complete_valid |-> complete_rob_idx == exp_crob)
		else value_err("complete_rob_idx_o", 64'($sampled(complete_rob_idx)),
			64'($sampled(exp_crob)));
	a_rv: assert property (@(posedge clk) disable iff (rst) recovery_valid == exp_rv)
		else value_err("recovery_valid_o", 64'($sampled(recovery_valid)), 64'($sampled(exp_rv)));
	a_rtgt: assert property (@(posedge clk) disable iff (rst)
		recovery_valid |-> recovery_target == exp_rtgt)
		else value_err("recovery_target_o", $sampled(recovery_target), $sampled(exp_rtgt));
	a_rrob: assert property (@(posedge clk) disable iff (rst)
		recovery_valid |-> recovery_rob_idx == exp_rrob)
		else value_err("recovery_rob_idx_o", 64'($sampled(recovery_rob_idx)),
			64'($sampled(exp_rrob)));
	a_mc: assert property (@(posedge clk) disable iff (rst) mispredict_count == exp_mc)
		else value_err("mispredict_count_o", 64'($sampled(mispredict_count)),
			64'($sampled(exp_mc)));
	a_pv: assert property (@(posedge clk) disable iff (rst) pred_valid == exp_pv)
		else value_err("pred_valid_o", 64'($sampled(pred_valid)), 64'($sampled(exp_pv)));
	a_pt: assert property (@(posedge clk) disable iff (rst) pred_valid |-> pred_taken == exp_pt)
		else value_err("pred_taken_o", 64'($sampled(pred_taken)), 64'($sampled(exp_pt)));

	// First edge out of reset
	a_rst: assert property (@(posedge clk) $fell(rst) |-> !complete_valid && !recovery_valid
		&& !pred_valid && (mispredict_count == '0))
		else
		begin
			misc_errs++;
			$display("Reset left a strobe high or the mispredict count nonzero");
		end

	always @(posedge clk)
	begin
		cyc <= cyc + 32'd1;
		if (cyc >= TIMEOUT_CYC)
		begin
			$display("Timeout, stimulus still running after %0d cycles", TIMEOUT_CYC);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		addr_t train_pc;
		issue_valid = 1'b0;
		issue_npc = '0;
		issue_opa = '0;
		issue_inst = '0;
		issue_rob_idx = '0;
		issue_pred_taken = 1'b0;
		issue_pred_target = '0;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		look_fixed = 1'b0;
		look_pc = '0;
		void'($urandom(99));
		@(negedge rst);
		idle(8);   // Lookups on a fresh table

		// All eight conditions back to back with right predictions
		for (int f = 0; f < 8; f++)
			for (int k = 0; k < 6; k++)
				send_branch(OP_CBR_BASE | opcode_t'(f), rand_pc(), pick_opa(k), 1'b0);
		idle(3);

		// Recovery addresses spaced past the squash window
		for (int k = 0; k < 6; k++)
		begin
			send_branch(OP_BR, rand_pc(), rand_addr(), 1'b1);
			idle(3);
			send_branch(OP_BSR, rand_pc(), rand_addr(), 1'b1);
			idle(3);
			send_branch(OP_JMP, rand_pc(), rand_addr(), 1'b1);
			idle(3);
			send_branch(OP_CBR_BASE | opcode_t'($urandom_range(7)), rand_pc(), pick_opa(k), 1'b1);
			idle(3);
			send_branch(OP_JMP, rand_pc(), rand_addr(), 1'b0); // Good guess gives no recovery
		end
		idle(3);

		// Two wrong-path issues and then one at a growing gap
		for (int k = 0; k < 4; k++)
		begin
			send_branch(OP_BR, rand_pc(), rand_addr(), 1'b1);
			send_branch(OP_CBR_BASE | 6'h1, rand_pc(), pick_opa(k), 1'b0);
			send_branch(OP_JMP, rand_pc(), rand_addr(), 1'b1);
			idle(k);
			send_branch(OP_JMP, rand_pc(), rand_addr(), 1'b0);
			idle(2);
		end
		idle(3);

		// Counter training at one PC
		train_pc = rand_pc();
		look_pc = train_pc;
		look_fixed = 1'b1;
		repeat (4)
		begin
			send_branch(OP_CBR_BASE | 6'h5, train_pc + 64'd4, 64'd7, 1'b0); // Taken BNE
			idle(2);
		end
		send_branch(OP_BR, rand_pc(), rand_addr(), 1'b1);
		send_branch(OP_CBR_BASE | 6'h1, train_pc + 64'd4, 64'd7, 1'b0); // Squashed BEQ
		idle(3);
		send_branch(OP_CBR_BASE | 6'h1, train_pc + 64'd4, 64'd7, 1'b0); // Not-taken BEQ
		idle(2);
		// Unconditional BR while the counter sits at weakly taken
		send_branch(OP_BR, train_pc + 64'd4, rand_addr(), 1'b0);
		idle(2);
		repeat (3)
		begin
			send_branch(OP_CBR_BASE | 6'h1, train_pc + 64'd4, 64'd7, 1'b0); // Not-taken BEQ
			idle(2);
		end
		look_fixed = 1'b0;
		idle(6);

		if (br_q.size() != 0)
		begin
			misc_errs++;
			$display("Model still holds %0d branches that never resolved", br_q.size());
		end
		if (m_miss == 0)
		begin
			misc_errs++;
			$display("No mispredict was exercised");
		end
		$display("Errors: %0d value, %0d other", val_errs, misc_errs);
		if ((val_errs == 0) && (misc_errs == 0))
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
source/br_pkg.sv
source/br_result_if.sv
source/br_cond_eval.sv
source/br_exec_unit.sv
source/br_predictor.sv
source/br_resolve_ctrl.sv
source/br_unit_top.sv
tests/br_tb_clkgen.sv
tests/br_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the branch unit testbench, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module br_tb -f project.f -o br_tb_sim \
	> sim.log 2>&1 && ./obj_dir/br_tb_sim >> sim.log 2>&1
grep -q "^test passed$" sim.log && exit 0 || { cat sim.log; exit 1; }
